// ==== hw/activation_gate_vector.sv ====
// Gate vector a(l) = tanh(W(l)x + U(l)h + b(l)) over rows 0 to L-1
// Host streams each row with its vector elements, the vector is resent per row
// Streams may interleave, but none may run more than one row ahead
// No back-pressure, all strobes are single cycle pulses

`timescale 1ns/1ns

module activation_gate_vector (
  // Global
  input  logic                                   CLK,
  input  logic                                   RST,

  // Control
  input  logic                                   START,
  output logic                                   READY,
  input  logic        [ntm_gate_pkg::SIZE_W-1:0] SIZE_X_IN,
  input  logic        [ntm_gate_pkg::SIZE_W-1:0] SIZE_L_IN,

  // Input projection pairs
  input  logic                                   W_X_ENABLE,
  input  logic signed [ntm_gate_pkg::DATA_W-1:0] W_IN,
  input  logic signed [ntm_gate_pkg::DATA_W-1:0] X_IN,

  // Recurrent projection pairs
  input  logic                                   U_H_ENABLE,
  input  logic signed [ntm_gate_pkg::DATA_W-1:0] U_IN,
  input  logic signed [ntm_gate_pkg::DATA_W-1:0] H_IN,

  // Row bias
  input  logic                                   B_IN_ENABLE,
  input  logic signed [ntm_gate_pkg::DATA_W-1:0] B_IN,

  // Gate output
  output logic                                   A_OUT_ENABLE,
  output logic signed [ntm_gate_pkg::DATA_W-1:0] A_OUT
);

  // Engine row results
  logic                                   in_valid;
  logic signed [ntm_gate_pkg::ACC_W-1:0]  in_sum;
  logic                                   rec_valid;
  logic signed [ntm_gate_pkg::ACC_W-1:0]  rec_sum;

  // W(l) . x, row length X
  dot_product_engine input_projection (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .size_in    (SIZE_X_IN),
    .elem_enable(W_X_ENABLE),
    .a_in       (W_IN),
    .b_in       (X_IN),
    .row_valid  (in_valid),
    .row_sum    (in_sum)
  );

  // U(l) . h, row length L
  dot_product_engine recurrent_projection (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .size_in    (SIZE_L_IN),
    .elem_enable(U_H_ENABLE),
    .a_in       (U_IN),
    .b_in       (H_IN),
    .row_valid  (rec_valid),
    .row_sum    (rec_sum)
  );

  // Bias add and tanh
  gate_combiner combiner (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .size_l_in  (SIZE_L_IN),
    .in_valid   (in_valid),
    .in_sum     (in_sum),
    .rec_valid  (rec_valid),
    .rec_sum    (rec_sum),
    .bias_enable(B_IN_ENABLE),
    .bias_in    (B_IN),
    .a_enable   (A_OUT_ENABLE),
    .a_out      (A_OUT),
    .ready      (READY)
  );

endmodule

// ==== hw/dot_product_engine.sv ====
// Streamed multiply-accumulate over one matrix row
// One element pair per strobe, no acknowledge, no back-pressure
// Row length is latched at START and must be nonzero
// row_valid pulses one cycle after the last element of a row

`timescale 1ns/1ns

module dot_product_engine (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   START,
  input  logic        [ntm_gate_pkg::SIZE_W-1:0] size_in,
  input  logic                                   elem_enable,
  input  logic signed [ntm_gate_pkg::DATA_W-1:0] a_in,
  input  logic signed [ntm_gate_pkg::DATA_W-1:0] b_in,
  output logic                                   row_valid,
  output logic signed [ ntm_gate_pkg::ACC_W-1:0] row_sum
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  logic        [ntm_gate_pkg::SIZE_W-1:0]   size_q;       // Row length
  logic        [ntm_gate_pkg::SIZE_W-1:0]   elem_cnt;     // Elements taken this row
  logic                                     started;      // Seen a START since reset
  logic                                     last_elem;

  logic signed [2*ntm_gate_pkg::DATA_W-1:0] product;      // Q16.16
  logic signed [ ntm_gate_pkg::ACC_W-1:0]   product_ext;
  logic signed [ ntm_gate_pkg::ACC_W-1:0]   acc;
  logic signed [ ntm_gate_pkg::ACC_W-1:0]   acc_next;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  assign product = a_in * b_in;  // Full width, no rounding here

  // Sign extend into the accumulator width
  assign product_ext = {
    {(ntm_gate_pkg::ACC_W - 2 * ntm_gate_pkg::DATA_W) {product[2*ntm_gate_pkg::DATA_W-1]}},
    product
  };

  assign acc_next  = acc + product_ext;
  assign last_elem = elem_enable && (elem_cnt == size_q - 1'b1);

  // Accumulator and row total
  always_ff @(posedge CLK) begin
    if (START) begin
      acc <= '0;  // Fresh vector
    end else if (last_elem) begin
      row_sum <= acc_next;  // Includes the last product
      acc     <= '0;        // Next row may follow at once
    end else if (elem_enable) begin
      acc <= acc_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_q    <= '0;
      elem_cnt  <= '0;
      started   <= 1'b0;
      row_valid <= 1'b0;
    end else begin
      row_valid <= last_elem;  // One cycle pulse

      if (START) begin
        size_q   <= size_in;
        elem_cnt <= '0;
        started  <= 1'b1;
      end else if (last_elem) begin
        elem_cnt <= '0;  // Wrap for the next row
      end else if (elem_enable) begin
        elem_cnt <= elem_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Host must open a vector before streaming into it
  assert property (@(posedge CLK) disable iff (RST) elem_enable |-> started)
  else $error("element strobe before first START");

  // A zero length would never close a row
  assert property (@(posedge CLK) disable iff (RST)
    started && !START |-> size_q != '0)
  else $error("row length latched as zero");

endmodule

// ==== hw/gate_combiner.sv ====
// Pairs the two projection row sums with the row bias and applies tanh
// Holds one pending item per source, a second one before pairing is an error
// Total is floored to Q8.8 and saturated before the piecewise tanh
// a_enable follows the last of the three row inputs by exactly 2 cycles
// ready pulses once, the cycle after the output of the last row

`timescale 1ns/1ns

module gate_combiner (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   START,
  input  logic        [ntm_gate_pkg::SIZE_W-1:0] size_l_in,
  input  logic                                   in_valid,
  input  logic signed [ ntm_gate_pkg::ACC_W-1:0] in_sum,
  input  logic                                   rec_valid,
  input  logic signed [ ntm_gate_pkg::ACC_W-1:0] rec_sum,
  input  logic                                   bias_enable,
  input  logic signed [ntm_gate_pkg::DATA_W-1:0] bias_in,
  output logic                                   a_enable,
  output logic signed [ntm_gate_pkg::DATA_W-1:0] a_out,
  output logic                                   ready
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Pending items, one per source
  logic                                   in_full, rec_full, bias_full;
  logic signed [ ntm_gate_pkg::ACC_W-1:0] in_q, rec_q;
  logic signed [ntm_gate_pkg::DATA_W-1:0] bias_q;

  // Row pairing
  logic                                   in_have, rec_have, bias_have;
  logic                                   row_fire;  // All three parts present
  logic signed [ ntm_gate_pkg::ACC_W-1:0] in_eff, rec_eff;
  logic signed [ntm_gate_pkg::DATA_W-1:0] bias_eff;

  // Stage 1, sum and narrowing
  logic signed [ ntm_gate_pkg::ACC_W-1:0] bias_ext;
  logic signed [ ntm_gate_pkg::ACC_W-1:0] total;    // Q16.16
  logic signed [ ntm_gate_pkg::ACC_W-1:0] floored;  // Integer Q8.8 steps
  logic signed [ntm_gate_pkg::DATA_W-1:0] narrow;
  logic signed [ntm_gate_pkg::DATA_W-1:0] sum_q;
  logic                                   sum_valid;

  // Stage 2, tanh on the magnitude
  logic        [  ntm_gate_pkg::DATA_W:0] sum_ext;   // One extra bit for -32768
  logic        [  ntm_gate_pkg::DATA_W:0] mag;
  logic        [  ntm_gate_pkg::DATA_W:0] tanh_mag;
  logic signed [ntm_gate_pkg::DATA_W-1:0] a_next;

  // Row counting
  logic        [ntm_gate_pkg::SIZE_W-1:0] size_l_q;
  logic        [ntm_gate_pkg::SIZE_W-1:0] row_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1
  ////////////////////////////////////////////////////////////////////////////

  assign in_have   = in_full | in_valid;
  assign rec_have  = rec_full | rec_valid;
  assign bias_have = bias_full | bias_enable;
  assign row_fire  = in_have & rec_have & bias_have;

  // Pending copy if held, else the item arriving now
  assign in_eff   = in_full ? in_q : in_sum;
  assign rec_eff  = rec_full ? rec_q : rec_sum;
  assign bias_eff = bias_full ? bias_q : bias_in;

  always_comb begin
    bias_ext = {{(ntm_gate_pkg::ACC_W - ntm_gate_pkg::DATA_W) {bias_eff[ntm_gate_pkg::DATA_W-1]}},
                bias_eff};
    total    = in_eff + rec_eff + (bias_ext <<< ntm_gate_pkg::FRAC_W);  // Bias to Q16.16
    floored  = total >>> ntm_gate_pkg::FRAC_W;  // Floor toward minus infinity

    // Clamp into the Q8.8 range
    if (floored > ntm_gate_pkg::SAT_MAX) begin
      narrow = ntm_gate_pkg::SAT_MAX;
    end else if (floored < ntm_gate_pkg::SAT_MIN) begin
      narrow = ntm_gate_pkg::SAT_MIN;
    end else begin
      narrow = floored[ntm_gate_pkg::DATA_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sum_ext = {sum_q[ntm_gate_pkg::DATA_W-1], sum_q};
    mag     = sum_q[ntm_gate_pkg::DATA_W-1] ? -sum_ext : sum_ext;

    if (mag <= (ntm_gate_pkg::DATA_W + 1)'(ntm_gate_pkg::TANH_KNEE_LO)) begin
      tanh_mag = mag;  // Linear region
    end else if (mag <= (ntm_gate_pkg::DATA_W + 1)'(ntm_gate_pkg::TANH_KNEE_HI)) begin
      // Half slope between the knees
      tanh_mag = (ntm_gate_pkg::DATA_W + 1)'(ntm_gate_pkg::TANH_KNEE_LO)
               + ((mag - (ntm_gate_pkg::DATA_W + 1)'(ntm_gate_pkg::TANH_KNEE_LO)) >> 1);
    end else begin
      tanh_mag = (ntm_gate_pkg::DATA_W + 1)'(ntm_gate_pkg::ONE_Q);  // Flat at 1.0
    end

    // Odd symmetry
    a_next = sum_q[ntm_gate_pkg::DATA_W-1] ? -tanh_mag[ntm_gate_pkg::DATA_W-1:0]
                                           : tanh_mag[ntm_gate_pkg::DATA_W-1:0];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  // Payload
  always_ff @(posedge CLK) begin
    if (in_valid) in_q <= in_sum;
    if (rec_valid) rec_q <= rec_sum;
    if (bias_enable) bias_q <= bias_in;
    if (row_fire) sum_q <= narrow;
    if (sum_valid) a_out <= a_next;
  end

  // Flags, pipeline strobes and row counter
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      in_full   <= 1'b0;
      rec_full  <= 1'b0;
      bias_full <= 1'b0;
      sum_valid <= 1'b0;
      a_enable  <= 1'b0;
      ready     <= 1'b0;
      size_l_q  <= '0;
      row_cnt   <= '0;
    end else begin
      sum_valid <= row_fire;
      a_enable  <= sum_valid;
      ready     <= 1'b0;

      if (START) begin
        in_full   <= 1'b0;
        rec_full  <= 1'b0;
        bias_full <= 1'b0;
        size_l_q  <= size_l_in;
        row_cnt   <= '0;
      end else begin
        if (row_fire) begin  // Row consumed
          in_full   <= 1'b0;
          rec_full  <= 1'b0;
          bias_full <= 1'b0;
        end else begin
          if (in_valid) in_full <= 1'b1;
          if (rec_valid) rec_full <= 1'b1;
          if (bias_enable) bias_full <= 1'b1;
        end

        // Count emitted rows
        if (a_enable) begin
          if (row_cnt == size_l_q - 1'b1) begin
            ready   <= 1'b1;
            row_cnt <= '0;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // A stream ran more than one row ahead of the others
  assert property (@(posedge CLK) disable iff (RST)
    !((in_valid && in_full) || (rec_valid && rec_full) || (bias_enable && bias_full)))
  else $error("second row arrived while one is still pending");

  // Gate output bounded by tanh range
  assert property (@(posedge CLK) disable iff (RST)
    a_enable |-> (a_out >= -ntm_gate_pkg::ONE_Q) && (a_out <= ntm_gate_pkg::ONE_Q))
  else $error("gate output outside -1.0 to 1.0");

endmodule

// ==== hw/ntm_gate_pkg.sv ====
// Shared widths and constants for the gate vector datapath
// All data words are signed Q8.8, sums are carried as Q16.16
// Accumulator headroom covers up to 255 full-scale products per row
// Vector sizes are 1 to 255, a size of zero is not supported

package ntm_gate_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W = 16;  // Q8.8 word
  localparam int FRAC_W = 8;   // Fraction bits
  localparam int ACC_W  = 40;  // Q16.16 sum plus growth bits
  localparam int SIZE_W = 8;   // Vector length field

  ////////////////////////////////////////////////////////////////////////////
  // Q8.8 constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int ONE_Q = 1 << FRAC_W;  // 1.0

  // Piecewise tanh breakpoints
  // Slope 1 up to the low knee, slope 1/2 up to the high knee, flat above
  localparam int TANH_KNEE_LO = ONE_Q / 2;      // 0.5
  localparam int TANH_KNEE_HI = 3 * ONE_Q / 2;  // 1.5

  // Narrowing limits for the floored row total
  localparam logic signed [DATA_W-1:0] SAT_MAX = {1'b0, {(DATA_W - 1) {1'b1}}};
  localparam logic signed [DATA_W-1:0] SAT_MIN = {1'b1, {(DATA_W - 1) {1'b0}}};

endpackage

// ==== src.f ====
hw/ntm_gate_pkg.sv
hw/dot_product_engine.sv
hw/gate_combiner.sv
hw/activation_gate_vector.sv
testbench/tb_activation_gate_vector.sv

// ==== testbench/gate_patterns.txt ====
// S size_x size_l, then per row: size_x lines W w x, size_l lines U u h,
// one line B bias, one line A expected gate (all hex, Q8.8)
// Linear region, bias alone, floor of a fractional sum onto the low knee
S 02 02
W 0000 0100
W 0000 0200
U 0000 0080
U 0000 0040
B 0040
A 0040
W 0100 0020
W 0080 0010
U 0010 0003
U 0001 0001
B 0058
A 0080
// Knee segment, its mirror, floor applied before the magnitude
S 01 03
W 0100 00C8
U 0000 0000
U 0000 0000
U 0000 0000
B 0000
A 00A4
W 0000 0000
U 0000 0000
U 0000 0000
U 0000 0000
B FF38
A FF5C
W 0000 0000
U 0001 FFFF
U 0000 0000
U 0000 0000
B FF7F
A FF7F
// Unequal sizes, mixed signs, negative sum between the knees
S 05 02
W 0100 0100
W 0080 0100
W FF80 0100
W 0000 1234
W 0040 0040
U 0100 FF00
U 0020 0020
B 0010
A 0024
W FF00 0100
W 0000 0000
W 0000 0000
W 0000 0000
W 0000 0000
U 0000 0000
U 0000 0000
B FFD4
A FF2A
// Saturation high, single recurrent element
S 03 01
W 7FFF 7FFF
W 7FFF 7FFF
W 7FFF 7FFF
U 7FFF 7FFF
B 7FFF
A 0100
// Saturation low, single element on both streams
S 01 01
W 8000 7FFF
U 8000 7FFF
B 8000
A FF00

// ==== testbench/tb_activation_gate_vector.sv ====
// Testbench for the gate vector top level, run from the project root
// Stimulus and expected gates come from testbench/gate_patterns.txt
// Streams keep to the one-row-ahead rule, idle gaps are random per element
// Odd rows hold the bias until both engines have their row, so bias is last

`timescale 1ns/1ns

module tb_activation_gate_vector;

  localparam int CLK_PERIOD = 10;

  logic                                   CLK;
  logic                                   RST;
  logic                                   START;
  logic                                   READY;
  logic        [ntm_gate_pkg::SIZE_W-1:0] SIZE_X_IN;
  logic        [ntm_gate_pkg::SIZE_W-1:0] SIZE_L_IN;
  logic                                   W_X_ENABLE;
  logic signed [ntm_gate_pkg::DATA_W-1:0] W_IN;
  logic signed [ntm_gate_pkg::DATA_W-1:0] X_IN;
  logic                                   U_H_ENABLE;
  logic signed [ntm_gate_pkg::DATA_W-1:0] U_IN;
  logic signed [ntm_gate_pkg::DATA_W-1:0] H_IN;
  logic                                   B_IN_ENABLE;
  logic signed [ntm_gate_pkg::DATA_W-1:0] B_IN;
  logic                                   A_OUT_ENABLE;
  logic signed [ntm_gate_pkg::DATA_W-1:0] A_OUT;

  // Pattern contents, in file order
  logic        [7:0]  size_x_q[$];
  logic        [7:0]  size_l_q[$];
  logic        [31:0] wx_q[$];      // {w, x}
  logic        [31:0] uh_q[$];      // {u, h}
  logic signed [15:0] bias_q[$];
  logic signed [15:0] expect_q[$];
  int                 wx_gap[$];    // Idle cycles before each strobe
  int                 uh_gap[$];
  int                 bias_gap[$];

  int cyc;          // Rising edges so far
  int a_count;      // Gates seen in the current case
  int a_total;
  int a_edge;       // Edge of the latest gate output
  int ready_count;
  int wx_ptr;
  int uh_ptr;
  int b_ptr;
  int wx_rows;      // Rows fully sent this case
  int uh_rows;
  int wx_at [0:255];   // Edge that took the row's last W/X pair
  int uh_at [0:255];
  int bias_at [0:255];
  bit loaded;

  activation_gate_vector uut (
    .CLK(CLK), .RST(RST), .START(START), .READY(READY),
    .SIZE_X_IN(SIZE_X_IN), .SIZE_L_IN(SIZE_L_IN),
    .W_X_ENABLE(W_X_ENABLE), .W_IN(W_IN), .X_IN(X_IN),
    .U_H_ENABLE(U_H_ENABLE), .U_IN(U_IN), .H_IN(H_IN),
    .B_IN_ENABLE(B_IN_ENABLE), .B_IN(B_IN),
    .A_OUT_ENABLE(A_OUT_ENABLE), .A_OUT(A_OUT)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // Gate is due 2 edges after the last combiner input, engines add one edge
  function automatic int due_edge(input int r);
    int due;
    due = bias_at[r] + 2;
    if (wx_at[r] + 3 > due) due = wx_at[r] + 3;
    if (uh_at[r] + 3 > due) due = uh_at[r] + 3;
    return due;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Pattern file
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_patterns();
    int          fd;
    int          c;
    int          n;
    logic [15:0] v1;
    logic [15:0] v2;
    fd = $fopen("testbench/gate_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/gate_patterns.txt");
      $display("Errors found");
      $fatal(1);
    end
    c = $fgetc(fd);
    while (c != -1) begin
      n = 2;
      case (c)
        "/": while (c != "\n" && c != -1) c = $fgetc(fd);  // Comment line
        "S": begin
          n = $fscanf(fd, "%h %h", v1, v2);
          size_x_q.push_back(v1[7:0]);
          size_l_q.push_back(v2[7:0]);
        end
        "W": begin
          n = $fscanf(fd, "%h %h", v1, v2);
          wx_q.push_back({v1, v2});
        end
        "U": begin
          n = $fscanf(fd, "%h %h", v1, v2);
          uh_q.push_back({v1, v2});
        end
        "B": begin
          n = 1 + $fscanf(fd, "%h", v1);
          bias_q.push_back(v1);
        end
        "A": begin
          n = 1 + $fscanf(fd, "%h", v1);
          expect_q.push_back(v1);
        end
        default: ;  // Whitespace
      endcase
      if (n != 2) begin
        $display("Malformed record in the pattern file");
        $display("Errors found");
        $fatal(1);
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Host streams, row r may start once row r-2 has left the combiner
  ////////////////////////////////////////////////////////////////////////////

  task automatic feed_input_pairs(input int sx, input int rows);
    for (int r = 0; r < rows; r++) begin
      while (a_count + 1 < r) @(negedge CLK);
      for (int i = 0; i < sx; i++) begin
        repeat (wx_gap[wx_ptr]) @(negedge CLK);
        if (i == sx - 1) begin
          while (a_count < r) @(negedge CLK);  // Row r-1 gone before row r closes
        end
        W_X_ENABLE = 1'b1;
        {W_IN, X_IN} = wx_q[wx_ptr];
        wx_at[r] = cyc + 1;  // Taken at the next rising edge
        wx_ptr++;
        @(negedge CLK);
        W_X_ENABLE = 1'b0;
      end
      wx_rows <= wx_rows + 1;  // Seen by the bias stream one edge later
    end
  endtask

  task automatic send_recurrent_pairs(input int rows);
    for (int r = 0; r < rows; r++) begin
      while (a_count + 1 < r) @(negedge CLK);
      for (int i = 0; i < rows; i++) begin
        repeat (uh_gap[uh_ptr]) @(negedge CLK);
        if (i == rows - 1) begin
          while (a_count < r) @(negedge CLK);
        end
        U_H_ENABLE = 1'b1;
        {U_IN, H_IN} = uh_q[uh_ptr];
        uh_at[r] = cyc + 1;
        uh_ptr++;
        @(negedge CLK);
        U_H_ENABLE = 1'b0;
      end
      uh_rows <= uh_rows + 1;
    end
  endtask

  task automatic deliver_biases(input int rows);
    for (int r = 0; r < rows; r++) begin
      while (a_count + 1 < r) @(negedge CLK);
      if (r % 2 == 1) begin
        while (wx_rows <= r || uh_rows <= r) @(negedge CLK);  // Bias last
      end
      repeat (bias_gap[b_ptr]) @(negedge CLK);
      B_IN_ENABLE = 1'b1;
      B_IN = bias_q[b_ptr];
      bias_at[r] = cyc + 1;
      b_ptr++;
      @(negedge CLK);
      B_IN_ENABLE = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output checker, samples at the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    cyc = cyc + 1;
    if (START) a_count = 0;
    if (A_OUT_ENABLE) begin
      check_value("A_OUT", expect_q[a_total], A_OUT);
      check_value("A_OUT_ENABLE edge", due_edge(a_count), cyc);
      a_count = a_count + 1;
      a_total = a_total + 1;
      a_edge  = cyc;
    end
    if (READY) begin
      check_value("A_OUT_ENABLE count at READY", size_l_q[ready_count], a_count);
      check_value("READY edge", a_edge + 1, cyc);  // Cycle after the last gate
      ready_count = ready_count + 1;
    end
  end

  // Limit from the element count in the file
  initial begin
    wait (loaded);
    #((wx_q.size() + uh_q.size() + bias_q.size()) * 4 * CLK_PERIOD + 200 * CLK_PERIOD);
    $display("Timed out waiting for gate output at %0t", $time);
    $display("Errors found");
    $fatal(1);
  end

  initial begin
    CLK = 1'b0;
    RST = 1'b1;
    START = 1'b0;
    SIZE_X_IN = '0;
    SIZE_L_IN = '0;
    W_X_ENABLE = 1'b0;
    W_IN = '0;
    X_IN = '0;
    U_H_ENABLE = 1'b0;
    U_IN = '0;
    H_IN = '0;
    B_IN_ENABLE = 1'b0;
    B_IN = '0;
    void'($urandom(32'hb380_b019));
    load_patterns();
    foreach (wx_q[i]) wx_gap.push_back($urandom % 3);
    foreach (uh_q[i]) uh_gap.push_back($urandom % 3);
    foreach (bias_q[i]) bias_gap.push_back($urandom % 4);
    loaded = 1'b1;
    repeat (5) @(negedge CLK);
    RST = 1'b0;

    for (int c = 0; c < size_x_q.size(); c++) begin
      @(negedge CLK);
      SIZE_X_IN = size_x_q[c];
      SIZE_L_IN = size_l_q[c];
      START = 1'b1;
      @(negedge CLK);
      START = 1'b0;
      wx_rows = 0;
      uh_rows = 0;
      fork
        feed_input_pairs(size_x_q[c], size_l_q[c]);
        send_recurrent_pairs(size_l_q[c]);
        deliver_biases(size_l_q[c]);
      join
      while (ready_count <= c) @(negedge CLK);
      repeat (3) @(negedge CLK);  // Room for a stray second READY
    end

    check_value("A_OUT_ENABLE total", expect_q.size(), a_total);
    check_value("READY total", size_x_q.size(), ready_count);
    $display("No errors");
    $finish;
  end

endmodule
